/* logic/exception_ctrl.sv */
`timescale 1ns/1ps

module exception_ctrl
    import riscv_isa_pkg::*;
    import pipe_pkg::*;
(
    input  if_id_t id_stage,
    input  logic   is_illegal_ir,
    input  logic   is_ecall,
    input  logic   branch_taken,
    input  logic   redirect,
    output exc_t   id_exc
);

    logic       flush;
    logic       live;
    exc_cause_e cause;

    // The ID instruction is squashed by a branch or a trap redirect
    assign flush = branch_taken | redirect;
    assign live  = id_stage.valid && !flush;

    // Misalignment first: an illegal decode of a misaligned fetch follows from it
    always_comb
    begin
        if (!live)
            cause = EXC_NONE;
        else if (id_stage.i_addr_misaligned)
            cause = EXC_I_MISALIGN;
        else if (is_illegal_ir)
            cause = EXC_ILLEGAL;
        else if (is_ecall)
            cause = EXC_ECALL;
        else
            cause = EXC_NONE;
    end

    // Raised straight from the inputs, cross-checked against cause below
    assign id_exc.raised = live &&
        (id_stage.i_addr_misaligned || is_illegal_ir || is_ecall);
    assign id_exc.cause  = cause;
    assign id_exc.epc    = id_exc.raised ? id_stage.pc : '0;

    always_comb
    begin
        case (cause)
            // Faulting fetch address
            EXC_I_MISALIGN: id_exc.tval = id_stage.pc;
            // Offending instruction word
            EXC_ILLEGAL:    id_exc.tval = id_stage.ir;
            default:        id_exc.tval = '0;
        endcase
    end

    a_raised_cause: assert final (id_exc.raised == (id_exc.cause != EXC_NONE))
        else $error("exception_ctrl: raised disagrees with cause");

endmodule

/* logic/fetch_unit.sv */
`timescale 1ns/1ps

module fetch_unit
    import riscv_isa_pkg::*;
    import pipe_pkg::*;
#(
    parameter logic [31:0] RESET_PC    = 32'h0000_0000,
    parameter logic [31:0] TRAP_VECTOR = 32'h0000_0100
) (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            redirect,
    input  logic            branch_taken,
    input  logic [XLEN-1:0] branch_target,
    output logic [XLEN-1:0] imem_addr,
    input  logic [XLEN-1:0] imem_rdata,
    output if_id_t          if_stage
);

    logic [XLEN-1:0] pc_q;
    logic [XLEN-1:0] pc_next;

    // Next PC: trap redirect, then resolved branch, then sequential
    always_comb
    begin
        if (redirect)
            pc_next = TRAP_VECTOR;
        else if (branch_taken)
            pc_next = branch_target;
        else
            pc_next = pc_q + 32'd4;
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
            pc_q <= RESET_PC;
        else
            pc_q <= pc_next;
    end

    // Instruction memory is combinational, word comes back this cycle
    assign imem_addr = pc_q;

    always_comb
    begin
        if_stage.valid             = 1'b1;
        if_stage.pc                = pc_q;
        if_stage.ir                = imem_rdata;
        // Only 32-bit instructions, so any nonzero low bit is misaligned
        if_stage.i_addr_misaligned = |pc_q[1:0];
    end

    // A trap redirect overrides a branch resolved in the same cycle
    a_redirect_wins: assert property (@(posedge clk) disable iff (!rst_n)
        redirect |=> (pc_q == TRAP_VECTOR))
        else $error("fetch_unit: redirect did not load the trap vector");

endmodule

/* logic/if_id_reg.sv */
`timescale 1ns/1ps

module if_id_reg
    import pipe_pkg::*;
(
    input  logic   clk,
    input  logic   rst_n,
    input  logic   redirect,
    input  logic   branch_taken,
    input  if_id_t if_stage,
    output if_id_t id_stage
);

    logic   flush;
    if_id_t bubble;

    // Either control transfer kills the instruction now in IF
    assign flush = redirect | branch_taken;

    // Invalid entry carrying a NOP
    always_comb
    begin
        bubble.valid             = 1'b0;
        bubble.pc                = '0;
        bubble.ir                = NOP_WORD;
        bubble.i_addr_misaligned = 1'b0;
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n || flush)
            id_stage <= bubble;
        else
            id_stage <= if_stage;
    end

    // Nothing flushed may show up as valid in ID
    a_flush_bubble: assert property (@(posedge clk) disable iff (!rst_n)
        flush |=> !id_stage.valid)
        else $error("if_id_reg: valid entry after flush");

endmodule

/* logic/instr_decoder.sv */
`timescale 1ns/1ps

module instr_decoder
    import riscv_isa_pkg::*;
    import pipe_pkg::*;
(
    input  if_id_t id_stage,
    output logic   is_illegal_ir,
    output logic   is_ecall
);

    opcode_e opcode;
    logic    opcode_legal;
    logic    exact_ecall;

    // Values outside the enum simply fall to the default arm
    assign opcode = opcode_e'(id_stage.ir[OPCODE_W-1:0]);

    assign exact_ecall = (id_stage.ir == ECALL_WORD);

    always_comb
    begin
        case (opcode)
            OPC_LUI,
            OPC_AUIPC,
            OPC_JAL,
            OPC_JALR,
            OPC_BRANCH,
            OPC_LOAD,
            OPC_STORE,
            OPC_OP_IMM,
            OPC_OP:
                opcode_legal = 1'b1;
            // ECALL is the only SYSTEM instruction supported
            OPC_SYSTEM:
                opcode_legal = exact_ecall;
            default:
                opcode_legal = 1'b0;
        endcase
    end

    // Compressed or reserved length encodings are illegal too
    assign is_illegal_ir = (id_stage.ir[1:0] != ILEN32_TAG) || !opcode_legal;

    // Whole-word compare, no partial field match
    assign is_ecall = exact_ecall;

endmodule

/* logic/pipe_pkg.sv */
package pipe_pkg;

    // Canonical NOP: addi x0, x0, 0
    localparam logic [riscv_isa_pkg::XLEN-1:0] NOP_WORD = 32'h0000_0013;

    // Contents of the IF/ID pipeline register
    typedef struct packed {
        logic                            valid;
        logic [riscv_isa_pkg::XLEN-1:0]  pc;
        logic [riscv_isa_pkg::XLEN-1:0]  ir;
        // Detected at fetch, acted on in ID
        logic                            i_addr_misaligned;
    } if_id_t;

    // Exception record from ID to the trap registers
    typedef struct packed {
        logic                            raised;
        riscv_isa_pkg::exc_cause_e       cause;
        // PC of the faulting instruction
        logic [riscv_isa_pkg::XLEN-1:0]  epc;
        // Faulting address or instruction word
        logic [riscv_isa_pkg::XLEN-1:0]  tval;
    } exc_t;

endpackage

/* logic/riscv_isa_pkg.sv */
package riscv_isa_pkg;

    // Base integer width
    localparam int XLEN = 32;

    // Major opcode field sits in ir[6:0]
    localparam int OPCODE_W = 7;

    // Encodings of all 32-bit instructions end in 2'b11
    localparam logic [1:0] ILEN32_TAG = 2'b11;

    // ECALL: funct12=0, rs1=0, funct3=0, rd=0, SYSTEM
    localparam logic [XLEN-1:0] ECALL_WORD = 32'h0000_0073;

    // Major opcodes accepted by the decoder
    typedef enum logic [OPCODE_W-1:0] {
        OPC_LOAD   = 7'b0000011,
        OPC_OP_IMM = 7'b0010011,
        OPC_AUIPC  = 7'b0010111,
        OPC_STORE  = 7'b0100011,
        OPC_OP     = 7'b0110011,
        OPC_LUI    = 7'b0110111,
        OPC_BRANCH = 7'b1100011,
        OPC_JALR   = 7'b1100111,
        OPC_JAL    = 7'b1101111,
        OPC_SYSTEM = 7'b1110011
    } opcode_e;

    // Exception causes handled by the front end
    typedef enum logic [1:0] {
        EXC_NONE       = 2'd0,
        EXC_I_MISALIGN = 2'd1,
        EXC_ILLEGAL    = 2'd2,
        EXC_ECALL      = 2'd3
    } exc_cause_e;

    // Architectural mcause value, bit 31 clear since these are synchronous
    function automatic logic [XLEN-1:0] mcause_code(exc_cause_e cause);
        case (cause)
            EXC_ILLEGAL: mcause_code = 32'd2;
            // ECALL from M-mode
            EXC_ECALL:   mcause_code = 32'd11;
            // Misaligned fetch and no-exception both map to 0
            default:     mcause_code = 32'd0;
        endcase
    endfunction

endpackage

/* logic/trap_csr.sv */
`timescale 1ns/1ps

module trap_csr
    import riscv_isa_pkg::*;
    import pipe_pkg::*;
(
    input  logic            clk,
    input  logic            rst_n,
    input  exc_t            id_exc,
    output logic            redirect,
    output logic            trap_valid,
    output logic [XLEN-1:0] trap_cause,
    output logic [XLEN-1:0] trap_epc,
    output logic [XLEN-1:0] trap_tval
);

    logic            trap_q;
    logic [XLEN-1:0] mepc_q;
    logic [XLEN-1:0] mcause_q;
    logic [XLEN-1:0] mtval_q;

    // One-cycle strobe the cycle after the exception leaves ID
    always_ff @(posedge clk)
    begin
        if (!rst_n)
            trap_q <= 1'b0;
        else
            trap_q <= id_exc.raised;
    end

    // Trap record, held until the next exception overwrites it
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            mepc_q   <= '0;
            mcause_q <= '0;
            mtval_q  <= '0;
        end
        else if (id_exc.raised)
        begin
            mepc_q   <= id_exc.epc;
            mcause_q <= mcause_code(id_exc.cause);
            mtval_q  <= id_exc.tval;
        end
    end

    // Redirect and trap strobe are the same event
    assign redirect   = trap_q;
    assign trap_valid = trap_q;
    assign trap_cause = mcause_q;
    assign trap_epc   = mepc_q;
    assign trap_tval  = mtval_q;

    // The redirect must squash whatever follows the faulting instruction
    a_no_back_to_back: assert property (@(posedge clk) disable iff (!rst_n)
        trap_valid |=> !trap_valid)
        else $error("trap_csr: trap_valid high on consecutive cycles");

endmodule

/* logic/trap_frontend_top.sv */
`timescale 1ns/1ps

module trap_frontend_top
    import riscv_isa_pkg::*;
    import pipe_pkg::*;
#(
    parameter logic [31:0] RESET_PC    = 32'h0000_0000,
    parameter logic [31:0] TRAP_VECTOR = 32'h0000_0100
) (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            branch_taken,
    input  logic [XLEN-1:0] branch_target,
    output logic [XLEN-1:0] imem_addr,
    input  logic [XLEN-1:0] imem_rdata,
    output logic            trap_valid,
    output logic [XLEN-1:0] trap_cause,
    output logic [XLEN-1:0] trap_epc,
    output logic [XLEN-1:0] trap_tval
);

    if_id_t if_stage;
    if_id_t id_stage;
    exc_t   id_exc;
    logic   redirect;
    logic   is_illegal_ir;
    logic   is_ecall;

    // IF
    fetch_unit #(
        .RESET_PC    (RESET_PC),
        .TRAP_VECTOR (TRAP_VECTOR)
    ) u_fetch (
        .clk           (clk),
        .rst_n         (rst_n),
        .redirect      (redirect),
        .branch_taken  (branch_taken),
        .branch_target (branch_target),
        .imem_addr     (imem_addr),
        .imem_rdata    (imem_rdata),
        .if_stage      (if_stage)
    );

    // IF/ID boundary
    if_id_reg u_if_id (
        .clk          (clk),
        .rst_n        (rst_n),
        .redirect     (redirect),
        .branch_taken (branch_taken),
        .if_stage     (if_stage),
        .id_stage     (id_stage)
    );

    // ID classification
    instr_decoder u_decoder (
        .id_stage      (id_stage),
        .is_illegal_ir (is_illegal_ir),
        .is_ecall      (is_ecall)
    );

    exception_ctrl u_exc_ctrl (
        .id_stage      (id_stage),
        .is_illegal_ir (is_illegal_ir),
        .is_ecall      (is_ecall),
        .branch_taken  (branch_taken),
        .redirect      (redirect),
        .id_exc        (id_exc)
    );

    // Trap registers, redirect goes back to fetch and IF/ID
    trap_csr u_trap_csr (
        .clk        (clk),
        .rst_n      (rst_n),
        .id_exc     (id_exc),
        .redirect   (redirect),
        .trap_valid (trap_valid),
        .trap_cause (trap_cause),
        .trap_epc   (trap_epc),
        .trap_tval  (trap_tval)
    );

endmodule

/* verif/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD_NS    = 40,
    parameter int RESET_CYCLES = 3
) (
    output logic clk,
    output logic rst_n
);

    // Free-running clock, starts low
    initial
    begin
        clk = 1'b0;
        forever
            #(PERIOD_NS / 2) clk = ~clk;
    end

    // Reset low for a fixed number of rising edges, released on an edge
    initial
    begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

/* verif/trap_frontend_tb.sv */
`timescale 1ns/1ps

module trap_frontend_tb
    import riscv_isa_pkg::*;
();

    localparam logic [31:0] RESET_PC    = 32'h0000_0000;
    localparam logic [31:0] TRAP_VECTOR = 32'h0000_0100;
    localparam int          CLK_PERIOD  = 40;
    localparam int          MEM_WORDS   = 256;
    localparam logic [31:0] SEED        = 32'h03b1297a;
    // Opcode 7'b1111111 is outside the legal set
    localparam logic [31:0] BAD_WORD    = 32'h1357_9bff;

    // Program layout, one region per test
    localparam logic [31:0] ECALL_BASE   = 32'h0000_0200;
    localparam logic [31:0] ECALL_ADDR   = 32'h0000_0208;
    localparam logic [31:0] ILLEGAL_BASE = 32'h0000_0240;
    localparam logic [31:0] ILLEGAL_ADDR = 32'h0000_0248;
    localparam logic [31:0] MISALIGN_TGT = 32'h0000_0282;
    localparam logic [31:0] SQUASH_BASE  = 32'h0000_0300;
    localparam logic [31:0] SQUASH_ECALL = 32'h0000_0308;
    localparam logic [31:0] DETOUR_BASE  = 32'h0000_0340;
    localparam logic [31:0] DETOUR_BAD   = 32'h0000_0348;
    localparam logic [31:0] PAIR_BASE    = 32'h0000_0380;
    localparam logic [31:0] PAIR_ECALL   = 32'h0000_0388;

    // Cycle budget of each test, summed for the watchdog
    localparam int TEST_CYCLE_SUM  = 10 + 14 + 14 + 14 + 18 + 14;
    localparam int WATCHDOG_CYCLES = 40 * TEST_CYCLE_SUM;
    localparam int SETTLE_CYCLES   = 6;

    // Filler draws from the legal opcodes, SYSTEM left out
    localparam logic [6:0] FILLER_OPCODES [9] = '{
        OPC_LUI, OPC_AUIPC, OPC_JAL, OPC_JALR, OPC_BRANCH,
        OPC_LOAD, OPC_STORE, OPC_OP_IMM, OPC_OP
    };

    typedef struct packed {
        logic        raised;
        logic [31:0] cause;
        logic [31:0] epc;
        logic [31:0] tval;
    } trap_exp_t;

    logic        clk;
    logic        rst_n;
    logic        branch_taken;
    logic [31:0] branch_target;
    logic [31:0] imem_addr;
    logic [31:0] imem_rdata;
    logic        trap_valid;
    logic [31:0] trap_cause;
    logic [31:0] trap_epc;
    logic [31:0] trap_tval;
    logic [31:0] imem [MEM_WORDS];
    trap_exp_t   exp;
    int          error_count = 0;
    int          trap_count = 0;
    int          tests_passed = 0;
    int          tests_failed = 0;
    int          errors_at_start;
    int          traps_at_start;

    tb_clock_gen #(
        .PERIOD_NS    (CLK_PERIOD),
        .RESET_CYCLES (3)
    ) u_clk_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    trap_frontend_top #(
        .RESET_PC    (RESET_PC),
        .TRAP_VECTOR (TRAP_VECTOR)
    ) u_dut (
        .clk           (clk),
        .rst_n         (rst_n),
        .branch_taken  (branch_taken),
        .branch_target (branch_target),
        .imem_addr     (imem_addr),
        .imem_rdata    (imem_rdata),
        .trap_valid    (trap_valid),
        .trap_cause    (trap_cause),
        .trap_epc      (trap_epc),
        .trap_tval     (trap_tval)
    );

    // Word index from address bits 31 to 2, upper bits alias
    function automatic int word_index(input logic [31:0] addr);
        return addr[31:2] % MEM_WORDS;
    endfunction

    function automatic logic [31:0] random_legal_word();
        logic [31:0] r;
        r = $urandom;
        return {r[31:7], FILLER_OPCODES[$urandom % 9]};
    endfunction

    // Combinational instruction memory
    assign imem_rdata = imem[word_index(imem_addr)];

    task automatic load_program();
        for (int i = 0; i < MEM_WORDS; i++)
            imem[i] = random_legal_word();
        imem[word_index(ECALL_ADDR)]   = ECALL_WORD;
        imem[word_index(ILLEGAL_ADDR)] = BAD_WORD;
        // Misaligned target lands on an illegal word as well
        imem[word_index(MISALIGN_TGT)] = BAD_WORD;
        imem[word_index(SQUASH_ECALL)] = ECALL_WORD;
        imem[word_index(DETOUR_BAD)]   = BAD_WORD;
        // Illegal words right behind the ECALL must be squashed
        imem[word_index(PAIR_ECALL)]      = ECALL_WORD;
        imem[word_index(PAIR_ECALL + 4)]  = BAD_WORD;
        imem[word_index(PAIR_ECALL + 8)]  = BAD_WORD;
    endtask

    task automatic flag_error(input string msg);
        error_count++;
        $display("error at %0t ns: %s", $time, msg);
    endtask

    always @(posedge clk)
    begin
        if (rst_n && trap_valid)
            trap_count <= trap_count + 1;
    end

    // Fetch starts at RESET_PC once reset lifts
    a_reset_pc: assert property (@(posedge clk) $rose(rst_n) |-> imem_addr == RESET_PC)
        else flag_error($sformatf("first fetch at %h", $sampled(imem_addr)));

    a_seq_step: assert property (@(posedge clk) disable iff (!rst_n)
        (rst_n && !trap_valid && !branch_taken) |=> imem_addr == $past(imem_addr) + 32'd4)
        else flag_error($sformatf("sequential fetch went to %h", $sampled(imem_addr)));

    a_redirect_pc: assert property (@(posedge clk) disable iff (!rst_n)
        (rst_n && trap_valid) |=> imem_addr == TRAP_VECTOR)
        else flag_error($sformatf("fetch after trap at %h", $sampled(imem_addr)));

    a_branch_pc: assert property (@(posedge clk) disable iff (!rst_n)
        (rst_n && branch_taken && !trap_valid) |=> imem_addr == $past(branch_target))
        else flag_error($sformatf("fetch after branch at %h", $sampled(imem_addr)));

    a_no_back_to_back: assert property (@(posedge clk) disable iff (!rst_n)
        (rst_n && trap_valid) |=> !trap_valid)
        else flag_error("trap_valid high on two consecutive cycles");

    a_trap_expected: assert property (@(posedge clk) disable iff (!rst_n)
        (rst_n && trap_valid) |-> exp.raised)
        else flag_error($sformatf("unexpected trap, epc %h", $sampled(trap_epc)));

    a_trap_record: assert property (@(posedge clk) disable iff (!rst_n)
        (rst_n && trap_valid) |->
            (trap_cause == exp.cause && trap_epc == exp.epc && trap_tval == exp.tval))
        else flag_error($sformatf("trap cause %0d epc %h tval %h, expected %0d %h %h",
            $sampled(trap_cause), $sampled(trap_epc), $sampled(trap_tval),
            exp.cause, exp.epc, exp.tval));

    // Trap strobe two cycles after the faulting address is fetched
    a_trap_latency: assert property (@(posedge clk) disable iff (!rst_n)
        (rst_n && exp.raised && imem_addr == exp.epc) |-> ##2 trap_valid)
        else flag_error($sformatf("no trap two cycles after fetch of %h", exp.epc));

    task automatic begin_test(input trap_exp_t expect_trap);
        errors_at_start = error_count;
        traps_at_start  = trap_count;
        exp <= expect_trap;
    endtask

    // One-cycle branch pulse, called on a rising edge
    task automatic branch_to(input logic [31:0] target);
        branch_taken  <= 1'b1;
        branch_target <= target;
        @(posedge clk);
        branch_taken  <= 1'b0;
    endtask

    task automatic wait_for_trap();
        while (!trap_valid)
            @(posedge clk);
        repeat (SETTLE_CYCLES) @(posedge clk);
    endtask

    task automatic end_test(input string name, input int traps_expected);
        int traps_seen;
        traps_seen = trap_count - traps_at_start;
        a_trap_count: assert (traps_seen == traps_expected)
            else flag_error($sformatf("%0d traps in test, expected %0d",
                traps_seen, traps_expected));
        if (error_count == errors_at_start)
        begin
            tests_passed++;
            $display("test %s: pass", name);
        end
        else
        begin
            tests_failed++;
            $display("test %s: fail", name);
        end
    endtask

    initial
    begin
        void'($urandom(SEED));
        branch_taken  = 1'b0;
        branch_target = '0;
        exp           = '0;
        load_program();
        @(posedge clk);
        while (rst_n !== 1'b1)
            @(posedge clk);

        begin_test('{1'b0, 32'd0, 32'd0, 32'd0});
        repeat (10) @(posedge clk);
        end_test("reset and sequential fetch", 0);

        begin_test('{1'b1, 32'd11, ECALL_ADDR, 32'd0});
        branch_to(ECALL_BASE);
        wait_for_trap();
        end_test("ecall", 1);

        begin_test('{1'b1, 32'd2, ILLEGAL_ADDR, BAD_WORD});
        branch_to(ILLEGAL_BASE);
        wait_for_trap();
        end_test("illegal instruction", 1);

        begin_test('{1'b1, 32'd0, MISALIGN_TGT, MISALIGN_TGT});
        branch_to(MISALIGN_TGT);
        wait_for_trap();
        end_test("misaligned branch target", 1);

        // Second branch lands while the ECALL sits in ID
        begin_test('{1'b1, 32'd2, DETOUR_BAD, BAD_WORD});
        branch_to(SQUASH_BASE);
        do
            @(posedge clk);
        while (imem_addr != SQUASH_ECALL);
        branch_to(DETOUR_BASE);
        wait_for_trap();
        end_test("branch squashes ecall", 1);

        begin_test('{1'b1, 32'd11, PAIR_ECALL, 32'd0});
        branch_to(PAIR_BASE);
        wait_for_trap();
        end_test("redirect squashes next instruction", 1);

        $display("summary: %0d tests, %0d passed, %0d failed, %0d errors",
            tests_passed + tests_failed, tests_passed, tests_failed, error_count);
        if (error_count == 0)
            $display("TESTBENCH PASSED");
        else
            $display("TESTBENCH FAILED");
        $finish;
    end

    initial
    begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("watchdog expired after %0d cycles before all tests completed",
            WATCHDOG_CYCLES);
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

/* verilog.f */
logic/riscv_isa_pkg.sv
logic/pipe_pkg.sv
logic/fetch_unit.sv
logic/if_id_reg.sv
logic/instr_decoder.sv
logic/exception_ctrl.sv
logic/trap_csr.sv
logic/trap_frontend_top.sv
verif/tb_clock_gen.sv
verif/trap_frontend_tb.sv
